//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int funct3_w   = 3;
  localparam int funct7_w   = 7;
  localparam int shamt_w    = 5;

  // Base opcodes, inst[6:0]
  typedef enum logic [6:0] {
    lui      = 7'b0110111,
    auipc    = 7'b0010111,
    jal      = 7'b1101111,
    jalr     = 7'b1100111,
    branch   = 7'b1100011,
    load     = 7'b0000011,
    store    = 7'b0100011,
    op_imm   = 7'b0010011,
    op       = 7'b0110011,
    misc_mem = 7'b0001111,
    system   = 7'b1110011
  } opcode_e;

  localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
  localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
  localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
  localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
  localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
  localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;

  localparam logic [funct3_w-1:0] f3_byte  = 3'b000; // Loads and stores
  localparam logic [funct3_w-1:0] f3_half  = 3'b001;
  localparam logic [funct3_w-1:0] f3_word  = 3'b010;
  localparam logic [funct3_w-1:0] f3_byteu = 3'b100;
  localparam logic [funct3_w-1:0] f3_halfu = 3'b101;

  localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
  localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
  localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
  localparam logic [funct3_w-1:0] f3_sltu    = 3'b011;
  localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
  localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
  localparam logic [funct3_w-1:0] f3_or      = 3'b110;
  localparam logic [funct3_w-1:0] f3_and     = 3'b111;

  localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
  localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000; // sub, sra, srai

endpackage

//--- common/idu_pkg.sv
package idu_pkg;

  // One code per RV32I operation
  typedef enum logic [5:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lb, op_lh, op_lw, op_lbu, op_lhu,
    op_sb, op_sh, op_sw,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
    op_slli, op_srli, op_srai,
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    op_fence,
    op_ecall,
    op_ebreak,
    op_illegal
  } op_e;

  // Which fields an operation carries
  typedef enum logic [2:0] {
    fmt_r,
    fmt_i,
    fmt_i_shift,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_none
  } fmt_e;

endpackage

//--- hdl/inst_classifier.sv
`timescale 1ns/100ps

module inst_classifier (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ifu_vld,
  input  logic [rv_isa_pkg::xlen-1:0] ifu_inst,
  input  logic                        idu_rdy,
  output logic                        cls_vld,
  output idu_pkg::op_e                cls_op,
  output logic [rv_isa_pkg::xlen-1:0] cls_inst
);
  import rv_isa_pkg::*;
  import idu_pkg::*;

  logic [funct3_w-1:0] f3;
  logic [funct7_w-1:0] f7;
  op_e                 dec_op;

  assign f3 = ifu_inst[14:12];
  assign f7 = ifu_inst[31:25];

  always_comb begin
    dec_op = op_illegal; // Anything not matched below
    case (ifu_inst[6:0])
      lui:   dec_op = op_lui;
      auipc: dec_op = op_auipc;
      jal:   dec_op = op_jal;
      jalr:  dec_op = op_jalr;
      branch: begin
        case (f3)
          f3_beq:  dec_op = op_beq;
          f3_bne:  dec_op = op_bne;
          f3_blt:  dec_op = op_blt;
          f3_bge:  dec_op = op_bge;
          f3_bltu: dec_op = op_bltu;
          f3_bgeu: dec_op = op_bgeu;
          default: ;
        endcase
      end
      load: begin
        case (f3)
          f3_byte:  dec_op = op_lb;
          f3_half:  dec_op = op_lh;
          f3_word:  dec_op = op_lw;
          f3_byteu: dec_op = op_lbu;
          f3_halfu: dec_op = op_lhu;
          default: ;
        endcase
      end
      store: begin
        case (f3)
          f3_byte: dec_op = op_sb;
          f3_half: dec_op = op_sh;
          f3_word: dec_op = op_sw;
          default: ;
        endcase
      end
      op_imm: begin
        case (f3)
          f3_add_sub: dec_op = op_addi;
          f3_slt:     dec_op = op_slti;
          f3_sltu:    dec_op = op_sltiu;
          f3_xor:     dec_op = op_xori;
          f3_or:      dec_op = op_ori;
          f3_and:     dec_op = op_andi;
          f3_sll:     dec_op = op_slli;
          f3_srl_sra: begin
            if (f7 == f7_base) dec_op = op_srli;
            else if (f7 == f7_alt) dec_op = op_srai;
          end
          default: ;
        endcase
      end
      op: begin
        case (f3)
          f3_add_sub: begin
            if (f7 == f7_base) dec_op = op_add;
            else if (f7 == f7_alt) dec_op = op_sub;
          end
          f3_sll:  dec_op = op_sll;
          f3_slt:  dec_op = op_slt;
          f3_sltu: dec_op = op_sltu;
          f3_xor:  dec_op = op_xor;
          f3_srl_sra: begin
            if (f7 == f7_base) dec_op = op_srl;
            else if (f7 == f7_alt) dec_op = op_sra;
          end
          f3_or:   dec_op = op_or;
          f3_and:  dec_op = op_and;
          default: ;
        endcase
      end
      misc_mem: dec_op = op_fence;
      system:   dec_op = ifu_inst[20] ? op_ebreak : op_ecall; // imm[0] splits the pair
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cls_vld <= 1'b0;
    end else begin
      cls_vld <= ifu_vld & idu_rdy; // Strobes during !idu_rdy are lost
    end
  end

  always_ff @(posedge clk) begin
    cls_op   <= dec_op;
    cls_inst <= ifu_inst;
  end

endmodule

//--- inst_queue/inst_queue.sv
`timescale 1ns/100ps

module inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push,
  input  idu_pkg::op_e                push_op,
  input  logic [rv_isa_pkg::xlen-1:0] push_inst,
  input  logic                        pop,
  output logic                        empty,
  output idu_pkg::op_e                head_op,
  output logic [rv_isa_pkg::xlen-1:0] head_inst,
  output logic                        rdy
);
  import rv_isa_pkg::*;
  import idu_pkg::*;

  localparam int ptr_w = $clog2(QUEUE_DEPTH);
  localparam int cnt_w = ptr_w + 1;

  op_e              mem_op   [QUEUE_DEPTH];
  logic [xlen-1:0]  mem_inst [QUEUE_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_op[wr_ptr]   <= push_op;
      mem_inst[wr_ptr] <= push_inst;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  assign empty     = (count == '0);
  assign head_op   = mem_op[rd_ptr];
  assign head_inst = mem_inst[rd_ptr];

  // Keep a slot spare for the instruction still in the classifier
  assign rdy = (cnt_w'(QUEUE_DEPTH) - count) >= cnt_w'(2);

endmodule

//--- hdl/field_extractor.sv
`timescale 1ns/100ps

module field_extractor (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              idu_req,
  input  logic                              q_empty,
  input  idu_pkg::op_e                      q_op,
  input  logic [rv_isa_pkg::xlen-1:0]       q_inst,
  output logic                              q_pop,
  output logic                              idu_vld,
  output idu_pkg::op_e                      op,
  output logic [rv_isa_pkg::xlen-1:0]       imm,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  output logic [rv_isa_pkg::funct3_w-1:0]   funct3,
  output logic [rv_isa_pkg::funct7_w-1:0]   funct7,
  output logic [rv_isa_pkg::shamt_w-1:0]    shamt
);
  import rv_isa_pkg::*;
  import idu_pkg::*;

  fmt_e                  fmt;
  logic [xlen-1:0]       nxt_imm;
  logic [reg_addr_w-1:0] nxt_rs1;
  logic [reg_addr_w-1:0] nxt_rs2;
  logic [reg_addr_w-1:0] nxt_rd;
  logic [funct3_w-1:0]   nxt_funct3;
  logic [funct7_w-1:0]   nxt_funct7;
  logic [shamt_w-1:0]    nxt_shamt;

  assign q_pop = idu_req & ~q_empty;

  always_comb begin
    case (q_op)
      op_lui, op_auipc: fmt = fmt_u;
      op_jal:           fmt = fmt_j;
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: fmt = fmt_b;
      op_sb, op_sh, op_sw: fmt = fmt_s;
      op_slli, op_srli, op_srai: fmt = fmt_i_shift;
      op_jalr, op_lb, op_lh, op_lw, op_lbu, op_lhu,
      op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
      op_fence: fmt = fmt_i; // FENCE keeps fm/pred/succ in imm[11:0]
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and: fmt = fmt_r;
      default: fmt = fmt_none; // ecall, ebreak, illegal
    endcase
  end

  // Immediate bits at architectural positions, no sign extension
  always_comb begin
    nxt_imm    = '0;
    nxt_rs1    = '0;
    nxt_rs2    = '0;
    nxt_rd     = '0;
    nxt_funct3 = '0;
    nxt_funct7 = '0;
    nxt_shamt  = '0;
    case (fmt)
      fmt_r: begin
        nxt_funct7 = q_inst[31:25];
        nxt_rs2    = q_inst[24:20];
        nxt_rs1    = q_inst[19:15];
        nxt_funct3 = q_inst[14:12];
        nxt_rd     = q_inst[11:7];
      end
      fmt_i: begin
        nxt_imm[11:0] = q_inst[31:20];
        nxt_rs1       = q_inst[19:15];
        nxt_funct3    = q_inst[14:12];
        nxt_rd        = q_inst[11:7];
      end
      fmt_i_shift: begin
        nxt_funct7 = q_inst[31:25];
        nxt_shamt  = q_inst[24:20];
        nxt_rs1    = q_inst[19:15];
        nxt_funct3 = q_inst[14:12];
        nxt_rd     = q_inst[11:7];
      end
      fmt_s: begin
        nxt_imm[11:5] = q_inst[31:25];
        nxt_imm[4:0]  = q_inst[11:7];
        nxt_rs2       = q_inst[24:20];
        nxt_rs1       = q_inst[19:15];
        nxt_funct3    = q_inst[14:12];
      end
      fmt_b: begin
        nxt_imm[12]   = q_inst[31];
        nxt_imm[10:5] = q_inst[30:25];
        nxt_imm[4:1]  = q_inst[11:8];
        nxt_imm[11]   = q_inst[7];
        nxt_rs2       = q_inst[24:20];
        nxt_rs1       = q_inst[19:15];
        nxt_funct3    = q_inst[14:12];
      end
      fmt_u: begin
        nxt_imm[31:12] = q_inst[31:12];
        nxt_rd         = q_inst[11:7];
      end
      fmt_j: begin
        nxt_imm[20]    = q_inst[31];
        nxt_imm[10:1]  = q_inst[30:21];
        nxt_imm[11]    = q_inst[20];
        nxt_imm[19:12] = q_inst[19:12];
        nxt_rd         = q_inst[11:7];
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idu_vld <= 1'b0;
      op      <= op_illegal;
      imm     <= '0;
      rs1     <= '0;
      rs2     <= '0;
      rd      <= '0;
      funct3  <= '0;
      funct7  <= '0;
      shamt   <= '0;
    end else begin
      idu_vld <= q_pop;
      if (q_pop) begin // Outputs hold between pops
        op     <= q_op;
        imm    <= nxt_imm;
        rs1    <= nxt_rs1;
        rs2    <= nxt_rs2;
        rd     <= nxt_rd;
        funct3 <= nxt_funct3;
        funct7 <= nxt_funct7;
        shamt  <= nxt_shamt;
      end
    end
  end

endmodule

//--- hdl/idu_top.sv
`timescale 1ns/100ps

module idu_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              ifu_vld,
  input  logic [rv_isa_pkg::xlen-1:0]       ifu_inst,
  input  logic                              idu_req,
  output logic                              idu_rdy,
  output logic                              idu_vld,
  output idu_pkg::op_e                      op,
  output logic [rv_isa_pkg::xlen-1:0]       imm,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  output logic [rv_isa_pkg::funct3_w-1:0]   funct3,
  output logic [rv_isa_pkg::funct7_w-1:0]   funct7,
  output logic [rv_isa_pkg::shamt_w-1:0]    shamt
);
  import rv_isa_pkg::*;
  import idu_pkg::*;

  logic            cls_vld;
  op_e             cls_op;
  logic [xlen-1:0] cls_inst;
  logic            q_empty;
  op_e             q_op;
  logic [xlen-1:0] q_inst;
  logic            q_pop;

  inst_classifier u_classifier (
    .clk      (clk),
    .rst_n    (rst_n),
    .ifu_vld  (ifu_vld),
    .ifu_inst (ifu_inst),
    .idu_rdy  (idu_rdy),
    .cls_vld  (cls_vld),
    .cls_op   (cls_op),
    .cls_inst (cls_inst)
  );

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cls_vld),
    .push_op   (cls_op),
    .push_inst (cls_inst),
    .pop       (q_pop),
    .empty     (q_empty),
    .head_op   (q_op),
    .head_inst (q_inst),
    .rdy       (idu_rdy)
  );

  field_extractor u_extractor (
    .clk     (clk),
    .rst_n   (rst_n),
    .idu_req (idu_req),
    .q_empty (q_empty),
    .q_op    (q_op),
    .q_inst  (q_inst),
    .q_pop   (q_pop),
    .idu_vld (idu_vld),
    .op      (op),
    .imm     (imm),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .funct3  (funct3),
    .funct7  (funct7),
    .shamt   (shamt)
  );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- sim/idu_checker.sv
`timescale 1ns/100ps

module idu_checker #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         push,
  input logic                         pop,
  input logic [$clog2(QUEUE_DEPTH):0] count
);

  localparam int cnt_w = $clog2(QUEUE_DEPTH) + 1;

  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < cnt_w'(QUEUE_DEPTH)))
    else $error("queue written while full");

  no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count != '0))
    else $error("queue popped while empty");

  count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= cnt_w'(QUEUE_DEPTH))
    else $error("queue count above depth");

endmodule

bind inst_queue idu_checker #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) u_checker (
  .clk   (clk),
  .rst_n (rst_n),
  .push  (push),
  .pop   (pop),
  .count (count)
);

//--- sim/idu_tb.sv
`timescale 1ns/100ps

module idu_tb;
  import idu_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int max_cycles  = 2000; // About five times the length of all tests

  localparam logic [31:0] format_insts [11] = '{
    {20'habcde, 5'd3, 7'b0110111},                               // lui
    {1'b1, 10'h155, 1'b1, 8'h5a, 5'd1, 7'b1101111},              // jal
    {12'h7f3, 5'd2, 3'b000, 5'd4, 7'b1100111},                   // jalr
    {7'b1010101, 5'd6, 5'd7, 3'b001, 5'b11011, 7'b1100011},      // bne
    {12'h8a5, 5'd9, 3'b101, 5'd10, 7'b0000011},                  // lhu
    {7'h55, 5'd11, 5'd12, 3'b010, 5'd13, 7'b0100011},            // sw
    {7'b0100000, 5'd17, 5'd14, 3'b101, 5'd15, 7'b0010011},       // srai
    {7'b0100000, 5'd18, 5'd19, 3'b000, 5'd20, 7'b0110011},       // sub
    {4'b0000, 4'b1111, 4'b0011, 5'd0, 3'b000, 5'd0, 7'b0001111}, // fence
    32'h0000_0073,                                               // ecall
    32'h0010_0073                                                // ebreak
  };

  localparam logic [31:0] illegal_insts [3] = '{
    32'h1234_567f,                                        // Undefined opcode
    {12'h123, 5'd1, 3'b011, 5'd2, 7'b0000011},            // Load funct3 3
    {7'b0000001, 5'd1, 5'd2, 3'b000, 5'd3, 7'b0110011}    // ADD with funct7 1
  };

  localparam logic [6:0] opcode_tbl [11] = '{
    7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011,
    7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111, 7'b1110011
  };

  logic        clk;
  logic        rst_n;
  logic        ifu_vld;
  logic [31:0] ifu_inst;
  logic        idu_req;
  logic        idu_rdy;
  logic        idu_vld;
  op_e         op;
  logic [31:0] imm;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  shamt;

  logic [31:0] sb [$];
  string       test_name = "startup";
  int          seed = 32'h4cd6_14eb;
  int          cycles = 0;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  idu_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .ifu_vld  (ifu_vld),
    .ifu_inst (ifu_inst),
    .idu_req  (idu_req),
    .idu_rdy  (idu_rdy),
    .idu_vld  (idu_vld),
    .op       (op),
    .imm      (imm),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .funct3   (funct3),
    .funct7   (funct7),
    .shamt    (shamt)
  );

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
      stop_on_error();
    end
  endtask

  // RV32I decode keyed on {funct7, funct3, opcode}
  function automatic op_e model_op(input logic [31:0] i);
    logic [16:0] key;
    key = {i[31:25], i[14:12], i[6:0]};
    if (i[6:0] == 7'b1110011) return i[20] ? op_ebreak : op_ecall;
    casez (key)
      17'b???????_???_0110111: return op_lui;
      17'b???????_???_0010111: return op_auipc;
      17'b???????_???_1101111: return op_jal;
      17'b???????_???_1100111: return op_jalr;
      17'b???????_000_1100011: return op_beq;
      17'b???????_001_1100011: return op_bne;
      17'b???????_100_1100011: return op_blt;
      17'b???????_101_1100011: return op_bge;
      17'b???????_110_1100011: return op_bltu;
      17'b???????_111_1100011: return op_bgeu;
      17'b???????_000_0000011: return op_lb;
      17'b???????_001_0000011: return op_lh;
      17'b???????_010_0000011: return op_lw;
      17'b???????_100_0000011: return op_lbu;
      17'b???????_101_0000011: return op_lhu;
      17'b???????_000_0100011: return op_sb;
      17'b???????_001_0100011: return op_sh;
      17'b???????_010_0100011: return op_sw;
      17'b???????_000_0010011: return op_addi;
      17'b???????_010_0010011: return op_slti;
      17'b???????_011_0010011: return op_sltiu;
      17'b???????_100_0010011: return op_xori;
      17'b???????_110_0010011: return op_ori;
      17'b???????_111_0010011: return op_andi;
      17'b???????_001_0010011: return op_slli;
      17'b0000000_101_0010011: return op_srli;
      17'b0100000_101_0010011: return op_srai;
      17'b0000000_000_0110011: return op_add;
      17'b0100000_000_0110011: return op_sub;
      17'b???????_001_0110011: return op_sll;
      17'b???????_010_0110011: return op_slt;
      17'b???????_011_0110011: return op_sltu;
      17'b???????_100_0110011: return op_xor;
      17'b0000000_101_0110011: return op_srl;
      17'b0100000_101_0110011: return op_sra;
      17'b???????_110_0110011: return op_or;
      17'b???????_111_0110011: return op_and;
      17'b???????_???_0001111: return op_fence;
      default:                 return op_illegal;
    endcase
  endfunction

  function automatic fmt_e model_fmt(input op_e o);
    case (o)
      op_lui, op_auipc: return fmt_u;
      op_jal: return fmt_j;
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: return fmt_b;
      op_sb, op_sh, op_sw: return fmt_s;
      op_slli, op_srli, op_srai: return fmt_i_shift;
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and: return fmt_r;
      op_ecall, op_ebreak, op_illegal: return fmt_none;
      default: return fmt_i; // Loads, ALU immediates, jalr, fence
    endcase
  endfunction

  task automatic compare_output(input logic [31:0] inst);
    op_e         e_op;
    fmt_e        f;
    logic [31:0] e_imm;
    logic        has_rs1;
    logic        has_rs2;
    logic        has_rd;
    logic        has_f7;
    e_op = model_op(inst);
    f    = model_fmt(e_op);
    case (f)
      fmt_i:   e_imm = {20'b0, inst[31:20]};
      fmt_s:   e_imm = {20'b0, inst[31:25], inst[11:7]};
      fmt_b:   e_imm = {19'b0, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      fmt_u:   e_imm = {inst[31:12], 12'b0};
      fmt_j:   e_imm = {11'b0, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: e_imm = '0;
    endcase
    has_rs1 = f inside {fmt_r, fmt_i, fmt_i_shift, fmt_s, fmt_b}; // Also gates funct3
    has_rs2 = f inside {fmt_r, fmt_s, fmt_b};
    has_rd  = f inside {fmt_r, fmt_i, fmt_i_shift, fmt_u, fmt_j};
    has_f7  = f inside {fmt_r, fmt_i_shift};
    check("op", 32'(e_op), 32'(op));
    check("imm", e_imm, imm);
    check("rs1", has_rs1 ? 32'(inst[19:15]) : 32'd0, 32'(rs1));
    check("rs2", has_rs2 ? 32'(inst[24:20]) : 32'd0, 32'(rs2));
    check("rd", has_rd ? 32'(inst[11:7]) : 32'd0, 32'(rd));
    check("funct3", has_rs1 ? 32'(inst[14:12]) : 32'd0, 32'(funct3));
    check("funct7", has_f7 ? 32'(inst[31:25]) : 32'd0, 32'(funct7));
    check("shamt", (f == fmt_i_shift) ? 32'(inst[24:20]) : 32'd0, 32'(shamt));
  endtask

  // Scoreboard sampled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (idu_vld) begin
        if (sb.size() == 0) begin
          $display("** Error: %s output strobe with no instruction outstanding", test_name);
          stop_on_error();
        end
        compare_output(sb.pop_front());
      end
      if (ifu_vld && idu_rdy) sb.push_back(ifu_inst);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("** Error: timeout in %s after %0d cycles", test_name, cycles);
      stop_on_error();
    end
  end

  function automatic logic [31:0] random_inst();
    logic [31:0] body;
    logic [6:0]  opc;
    logic [6:0]  f7;
    int          pick;
    body = $random(seed);
    pick = $unsigned($random(seed)) % 13;
    opc  = (pick < 11) ? opcode_tbl[pick] : body[6:0]; // Mostly valid opcodes
    case ($unsigned($random(seed)) % 4)
      0, 1:    f7 = 7'h00;
      2:       f7 = 7'h20;
      default: f7 = body[31:25];
    endcase
    return {f7, body[24:7], opc};
  endfunction

  task automatic send_inst(input logic [31:0] inst);
    @(posedge clk);
    ifu_vld  <= 1'b1;
    ifu_inst <= inst;
  endtask

  task automatic wait_for_drain();
    @(posedge clk);
    ifu_vld <= 1'b0;
    idu_req <= 1'b1;
    @(posedge clk);
    while (sb.size() != 0) @(posedge clk);
  endtask

  // Feeds instructions with idu_req low until idu_rdy falls
  task automatic fill_queue();
    int n;
    n = 0;
    @(posedge clk);
    idu_req <= 1'b0;
    do begin
      send_inst(format_insts[n % 11]);
      n++;
      @(negedge clk);
    end while (idu_rdy && n < 4 * QUEUE_DEPTH);
  endtask

  task automatic test_reset();
    test_name = "reset";
    @(negedge clk);
    check("idu_rdy", 32'd1, 32'(idu_rdy));
    check("imm", 32'd0, imm);
    check("rs1", 32'd0, 32'(rs1));
    check("rs2", 32'd0, 32'(rs2));
    check("rd", 32'd0, 32'(rd));
    check("funct3", 32'd0, 32'(funct3));
    check("funct7", 32'd0, 32'(funct7));
    check("shamt", 32'd0, 32'(shamt));
    @(posedge clk);
    idu_req <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      check("idu_vld", 32'd0, 32'(idu_vld));
    end
  endtask

  task automatic test_formats();
    test_name = "formats";
    foreach (format_insts[i]) send_inst(format_insts[i]);
    wait_for_drain();
  endtask

  task automatic test_illegal();
    test_name = "illegal";
    foreach (illegal_insts[i]) send_inst(illegal_insts[i]);
    wait_for_drain();
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    fill_queue();
    @(posedge clk);
    ifu_vld <= 1'b0;
    repeat (2) @(negedge clk);
    check("idu_rdy", 32'd0, 32'(idu_rdy));
    @(posedge clk);
    check("accepted", QUEUE_DEPTH, sb.size()); // One still in the classifier
    wait_for_drain();
  endtask

  task automatic test_drop();
    test_name = "drop";
    fill_queue();
    repeat (4) send_inst(random_inst());
    @(posedge clk);
    ifu_vld <= 1'b0;
    repeat (2) @(posedge clk);
    check("accepted", QUEUE_DEPTH, sb.size());
    wait_for_drain();
    repeat (8) begin
      @(negedge clk);
      check("idu_vld", 32'd0, 32'(idu_vld)); // Dropped ones never surface
    end
  endtask

  task automatic test_random();
    logic [31:0] r;
    int          sent;
    test_name = "random";
    sent = 0;
    while (sent < 200) begin
      @(posedge clk);
      r = $random(seed);
      idu_req  <= r[0];
      ifu_vld  <= r[1] | r[2];
      ifu_inst <= random_inst();
      if (r[1] | r[2]) sent++;
    end
    wait_for_drain();
  endtask

  initial begin
    ifu_vld  = 1'b0;
    ifu_inst = '0;
    idu_req  = 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    test_reset();
    test_formats();
    test_illegal();
    test_backpressure();
    test_drop();
    test_random();
    @(posedge clk);
    if (sb.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("** Error: %0d instructions never came out", sb.size());
      stop_on_error();
    end
  end

endmodule

//--- idu.f
common/rv_isa_pkg.sv
common/idu_pkg.sv
hdl/inst_classifier.sv
inst_queue/inst_queue.sv
hdl/field_extractor.sv
hdl/idu_top.sv
sim/clk_gen.sv
sim/idu_checker.sv
sim/idu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= idu_tb
FILELIST  ?= idu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
